// File: rv_isa_pkg.sv
package rv_isa_pkg;

    // ==================================================
    // Field widths
    // ==================================================
    localparam int opcode_w  = 7;
    localparam int reg_idx_w = 5;
    localparam int funct3_w  = 3;
    localparam int funct7_w  = 7;

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // ==================================================
    // Major opcodes
    // ==================================================
    localparam logic [opcode_w-1:0] op_r       = 7'b0110011;
    localparam logic [opcode_w-1:0] op_i_jump  = 7'b1100111;  // jalr
    localparam logic [opcode_w-1:0] op_i_load  = 7'b0000011;
    localparam logic [opcode_w-1:0] op_i_arith = 7'b0010011;
    localparam logic [opcode_w-1:0] op_i_sys   = 7'b1110011;
    localparam logic [opcode_w-1:0] op_i_fence = 7'b0001111;
    localparam logic [opcode_w-1:0] op_s       = 7'b0100011;
    localparam logic [opcode_w-1:0] op_b       = 7'b1100011;
    localparam logic [opcode_w-1:0] op_u_lui   = 7'b0110111;
    localparam logic [opcode_w-1:0] op_u_auipc = 7'b0010111;
    localparam logic [opcode_w-1:0] op_j       = 7'b1101111;

    // ==================================================
    // Instruction formats, MSB first
    // ==================================================
    typedef struct packed {
        logic [funct7_w-1:0] funct7;
        reg_idx_t            rs2;
        reg_idx_t            rs1;
        logic [funct3_w-1:0] funct3;
        reg_idx_t            rd;
        logic [opcode_w-1:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]         imm_11_0;
        reg_idx_t            rs1;
        logic [funct3_w-1:0] funct3;
        reg_idx_t            rd;
        logic [opcode_w-1:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]          imm_11_5;
        reg_idx_t            rs2;
        reg_idx_t            rs1;
        logic [funct3_w-1:0] funct3;
        logic [4:0]          imm_4_0;
        logic [opcode_w-1:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered across the word
    typedef struct packed {
        logic                imm_12;
        logic [5:0]          imm_10_5;
        reg_idx_t            rs2;
        reg_idx_t            rs1;
        logic [funct3_w-1:0] funct3;
        logic [3:0]          imm_4_1;
        logic                imm_11;
        logic [opcode_w-1:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]         imm_31_12;
        reg_idx_t            rd;
        logic [opcode_w-1:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                imm_20;
        logic [9:0]          imm_10_1;
        logic                imm_11;
        logic [7:0]          imm_19_12;
        reg_idx_t            rd;
        logic [opcode_w-1:0] opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

// File: rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    import rv_isa_pkg::*;

    // ==================================================
    // Control bits
    // ==================================================
    typedef struct packed {
        logic exec_a;   // Operand A is the PC
        logic exec_b;   // Operand B is the immediate
        logic ld_sd;    // Memory access
        logic mem_w;    // Store
        logic reg_w;    // Register write
        logic mem2reg;  // Writeback from memory
        logic bra;      // Conditional branch
        logic jmp;      // Unconditional jump
    } ctrl_t;

    // Per-format control words
    // Bit order: exec_a exec_b ld_sd mem_w reg_w mem2reg bra jmp
    localparam ctrl_t ctrl_none    = 8'b0000_0000;
    localparam ctrl_t ctrl_r       = 8'b0000_1000;
    localparam ctrl_t ctrl_i_arith = 8'b0100_1000;
    localparam ctrl_t ctrl_i_load  = 8'b0110_1100;
    localparam ctrl_t ctrl_s       = 8'b0111_0000;
    localparam ctrl_t ctrl_b       = 8'b1100_0010;
    localparam ctrl_t ctrl_i_jump  = 8'b0100_1001;
    localparam ctrl_t ctrl_j       = 8'b1100_1001;
    localparam ctrl_t ctrl_u_lui   = 8'b0100_1000;
    localparam ctrl_t ctrl_u_auipc = 8'b1100_1000;

    // ==================================================
    // ALU classes
    // ==================================================
    localparam int alu_class_w = 4;

    localparam logic [alu_class_w-1:0] alu_none   = 4'd0;
    localparam logic [alu_class_w-1:0] alu_reg    = 4'd1;
    localparam logic [alu_class_w-1:0] alu_imm    = 4'd2;
    localparam logic [alu_class_w-1:0] alu_add    = 4'd3;
    localparam logic [alu_class_w-1:0] alu_lui    = 4'd4;
    localparam logic [alu_class_w-1:0] alu_branch = 4'd5;

    // ==================================================
    // Decode bundle handed to execute
    // ==================================================
    typedef struct packed {
        ctrl_t                  ctrl;
        logic [alu_class_w-1:0] alu_class;
        logic [31:0]            imm;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic [funct3_w-1:0]    funct3;
        logic [funct7_w-1:0]    funct7;
        logic                   illegal;
    } dec_bundle_t;

endpackage

// File: imm_gen.sv
`timescale 1ns/1ns

module imm_gen
    import rv_isa_pkg::*;
(
    input  instr_u      instr,
    output logic [31:0] imm
);

    logic [opcode_w-1:0] opcode;
    logic [funct3_w-1:0] funct3;
    logic                is_shift_imm;
    logic                sign;

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.i_fmt.funct3;
    assign sign   = instr.r_fmt.funct7[6];

    // slli and srli/srai carry a 5-bit shamt
    assign is_shift_imm = ~funct3[1] & funct3[0];

    // ==================================================
    // Immediate by format
    // ==================================================
    always_comb begin
        imm = 32'd0;
        case (opcode)
            op_i_jump, op_i_load: begin
                imm = {{20{sign}}, instr.i_fmt.imm_11_0};
            end
            op_i_arith: begin
                if (is_shift_imm) begin
                    imm = {{27{sign}}, instr.i_fmt.imm_11_0[4:0]};
                end else begin
                    imm = {{20{sign}}, instr.i_fmt.imm_11_0};
                end
            end
            op_s: begin
                imm = {{20{sign}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
            end
            op_b: begin
                // Offset is always even
                imm = {{19{sign}},
                       instr.b_fmt.imm_12,
                       instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5,
                       instr.b_fmt.imm_4_1,
                       1'b0};
            end
            op_u_lui, op_u_auipc: begin
                imm = {instr.u_fmt.imm_31_12, 12'd0};
            end
            op_j: begin
                imm = {{11{sign}},
                       instr.j_fmt.imm_20,
                       instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11,
                       instr.j_fmt.imm_10_1,
                       1'b0};
            end
            default: begin
                // R-type, sys, fence and unknown
                imm = 32'd0;
            end
        endcase
    end

endmodule

// File: ctrl_decoder.sv
`timescale 1ns/1ns

module ctrl_decoder
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic [opcode_w-1:0]    opcode,
    output ctrl_t                  ctrl,
    output logic [alu_class_w-1:0] alu_class,
    output logic                   known
);

    // ==================================================
    // Opcode table
    // ==================================================
    always_comb begin
        // Unknown opcode falls through with everything low
        ctrl      = ctrl_none;
        alu_class = alu_none;
        known     = 1'b0;

        case (opcode)
            op_r: begin
                ctrl      = ctrl_r;
                alu_class = alu_reg;
                known     = 1'b1;
            end
            op_i_arith: begin
                ctrl      = ctrl_i_arith;
                alu_class = alu_imm;
                known     = 1'b1;
            end
            op_i_load: begin
                ctrl      = ctrl_i_load;
                alu_class = alu_add;
                known     = 1'b1;
            end
            op_s: begin
                ctrl      = ctrl_s;
                alu_class = alu_add;
                known     = 1'b1;
            end
            op_b: begin
                // Target is PC plus offset, compare done elsewhere
                ctrl      = ctrl_b;
                alu_class = alu_branch;
                known     = 1'b1;
            end
            op_i_jump: begin
                ctrl      = ctrl_i_jump;
                alu_class = alu_add;
                known     = 1'b1;
            end
            op_j: begin
                ctrl      = ctrl_j;
                alu_class = alu_add;
                known     = 1'b1;
            end
            op_u_lui: begin
                ctrl      = ctrl_u_lui;
                alu_class = alu_lui;
                known     = 1'b1;
            end
            op_u_auipc: begin
                ctrl      = ctrl_u_auipc;
                alu_class = alu_add;
                known     = 1'b1;
            end
            op_i_sys, op_i_fence: begin
                // Legal, but no datapath action here
                ctrl      = ctrl_none;
                alu_class = alu_none;
                known     = 1'b1;
            end
            default: begin
                ctrl      = ctrl_none;
                alu_class = alu_none;
                known     = 1'b0;
            end
        endcase
    end

endmodule

// File: decode_reg.sv
`timescale 1ns/1ns

module decode_reg
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  instr_u                 instr,
    input  logic [31:0]            imm,
    input  ctrl_t                  ctrl,
    input  logic [alu_class_w-1:0] alu_class,
    input  logic                   known,
    input  logic                   instr_valid,
    input  logic                   stall,
    input  logic                   flush,
    output dec_bundle_t            out,
    output logic                   out_valid
);

    dec_bundle_t next_bundle;
    logic        rd_is_zero;

    assign rd_is_zero = (instr.r_fmt.rd == '0);

    // ==================================================
    // Bundle assembly
    // ==================================================
    always_comb begin
        next_bundle.ctrl = ctrl;

        // Writes to x0 are dropped here
        if (rd_is_zero) begin
            next_bundle.ctrl.reg_w = 1'b0;
        end

        next_bundle.alu_class = alu_class;
        next_bundle.imm       = imm;
        next_bundle.rd        = instr.r_fmt.rd;
        next_bundle.rs1       = instr.r_fmt.rs1;
        next_bundle.rs2       = instr.r_fmt.rs2;
        next_bundle.funct3    = instr.r_fmt.funct3;
        next_bundle.funct7    = instr.r_fmt.funct7;
        next_bundle.illegal   = ~known;
    end

    // ==================================================
    // Stage register
    // ==================================================
    // Priority: reset, flush, stall, then load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out       <= '0;
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= instr_valid;
            if (instr_valid) begin
                out <= next_bundle;
            end
        end
    end

endmodule

// File: fetch_decode.sv
`timescale 1ns/1ns

module fetch_decode
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  instr_u      instr,
    input  logic        instr_valid,
    input  logic        stall,
    input  logic        flush,
    output dec_bundle_t out,
    output logic        out_valid
);

    logic [31:0]            imm;
    ctrl_t                  ctrl;
    logic [alu_class_w-1:0] alu_class;
    logic                   known;

    // Both decoders see the same word in parallel
    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    ctrl_decoder u_ctrl_decoder (
        .opcode    (instr.r_fmt.opcode),
        .ctrl      (ctrl),
        .alu_class (alu_class),
        .known     (known)
    );

    decode_reg u_decode_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .imm         (imm),
        .ctrl        (ctrl),
        .alu_class   (alu_class),
        .known       (known),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .out         (out),
        .out_valid   (out_valid)
    );

endmodule

// File: tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// ==================================================
// Random source
// ==================================================
// 32-bit Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'd99619;

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// One LFSR step per bit taken, LSB last
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_bit()};
    end
    return r;
endfunction

function automatic logic [31:0] rand_instr(input logic [6:0] op);
    logic [31:0] r;
    r = rand_bits(25);
    return {r[24:0], op};
endfunction

// ==================================================
// Reference decode
// ==================================================
// Row layout: known, alu class, exec_a exec_b ld_sd mem_w reg_w mem2reg bra jmp
function automatic logic [12:0] table_row(input logic [6:0] op);
    case (op)
        op_r:                 return {1'b1, alu_reg,    8'b0000_1000};
        op_i_arith:           return {1'b1, alu_imm,    8'b0100_1000};
        op_i_load:            return {1'b1, alu_add,    8'b0110_1100};
        op_s:                 return {1'b1, alu_add,    8'b0111_0000};
        op_b:                 return {1'b1, alu_branch, 8'b1100_0010};
        op_i_jump:            return {1'b1, alu_add,    8'b0100_1001};
        op_j:                 return {1'b1, alu_add,    8'b1100_1001};
        op_u_lui:             return {1'b1, alu_lui,    8'b0100_1000};
        op_u_auipc:           return {1'b1, alu_add,    8'b1100_1000};
        op_i_sys, op_i_fence: return {1'b1, alu_none,   8'b0000_0000};
        default:              return {1'b0, alu_none,   8'b0000_0000};
    endcase
endfunction

// Immediate straight from the word's bit positions
function automatic logic [31:0] expected_imm(input logic [31:0] w);
    case (w[6:0])
        op_i_jump, op_i_load: return {{20{w[31]}}, w[31:20]};
        op_i_arith: begin
            // Shift amount only for funct3 001 and 101
            if (w[13:12] == 2'b01) begin
                return {{27{w[31]}}, w[24:20]};
            end
            return {{20{w[31]}}, w[31:20]};
        end
        op_s:                 return {{20{w[31]}}, w[31:25], w[11:7]};
        op_b:                 return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        op_u_lui, op_u_auipc: return {w[31:12], 12'h000};
        op_j:                 return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default:              return 32'd0;
    endcase
endfunction

function automatic dec_bundle_t expected_bundle(input logic [31:0] w);
    dec_bundle_t b;
    logic [12:0] row;
    row         = table_row(w[6:0]);
    b.ctrl      = row[7:0];
    // No write back to x0
    b.ctrl.reg_w = row[3] & (w[11:7] != 5'd0);
    b.alu_class = row[11:8];
    b.imm       = expected_imm(w);
    b.rd        = w[11:7];
    b.rs1       = w[19:15];
    b.rs2       = w[24:20];
    b.funct3    = w[14:12];
    b.funct7    = w[31:25];
    b.illegal   = ~row[12];
    return b;
endfunction

`endif

// File: tb_fetch_decode.sv
`timescale 1ns/1ns

module tb_fetch_decode
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
();

    // About twice the cycles the tests below take
    localparam int max_cycles = 1200;
    localparam logic [6:0] all_ops [11] = '{op_r, op_i_jump, op_i_load, op_i_arith,
        op_i_sys, op_i_fence, op_s, op_b, op_u_lui, op_u_auipc, op_j};
    localparam logic [6:0] imm_ops [9] = '{op_i_load, op_i_jump, op_i_arith, op_i_arith,
        op_s, op_b, op_u_lui, op_u_auipc, op_j};

    logic        clk = 1'b0;
    logic        rst_n;
    instr_u      instr;
    logic        instr_valid;
    logic        stall;
    logic        flush;
    dec_bundle_t out;
    logic        out_valid;

    dec_bundle_t exp_bundle;
    logic        exp_valid;
    logic        loaded;
    dec_bundle_t prev_out;
    logic        prev_valid;
    logic        hold_q;
    logic        flush_q;
    string       test_name = "reset_idle";
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_done = 0;
    int          cycles = 0;

    `include "tb_decode_model.svh"

    fetch_decode dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .out         (out),
        .out_valid   (out_valid)
    );

    always #10 clk = ~clk;

    // ==================================================
    // Expected stage contents
    // ==================================================
    always @(posedge clk) begin
        hold_q     <= rst_n && stall && !flush;
        flush_q    <= rst_n && flush;
        prev_out   <= out;
        prev_valid <= out_valid;
        if (!rst_n) begin
            exp_bundle <= '0;
            exp_valid  <= 1'b0;
            loaded     <= 1'b0;
        end else if (flush) begin
            exp_valid <= 1'b0;
        end else if (!stall) begin
            exp_valid <= instr_valid;
            if (instr_valid) begin
                exp_bundle <= expected_bundle(instr);
                loaded     <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic report_value(input string field, input string expected, input string actual);
        errors++;
        $display("[FAIL] %s: %s expected %s, actual %s", test_name, field, expected, actual);
    endtask

    // ==================================================
    // Checks, sampled mid-cycle
    // ==================================================
    a_idle: assert property (@(negedge clk) !loaded |-> out == '0)
        else report_value("idle bundle", "0", $sformatf("%h", out));
    a_valid: assert property (@(negedge clk) out_valid == exp_valid)
        else report_value("out_valid", $sformatf("%b", exp_valid), $sformatf("%b", out_valid));
    a_ctrl: assert property (@(negedge clk) out_valid |-> out.ctrl == exp_bundle.ctrl)
        else report_value("ctrl", $sformatf("%b", exp_bundle.ctrl), $sformatf("%b", out.ctrl));
    a_alu: assert property (@(negedge clk) out_valid |-> out.alu_class == exp_bundle.alu_class)
        else report_value("alu_class", $sformatf("%0d", exp_bundle.alu_class),
                          $sformatf("%0d", out.alu_class));
    a_imm: assert property (@(negedge clk) out_valid |-> out.imm == exp_bundle.imm)
        else report_value("imm", $sformatf("%h", exp_bundle.imm), $sformatf("%h", out.imm));
    a_bundle: assert property (@(negedge clk) out_valid |-> out == exp_bundle)
        else report_value("bundle", $sformatf("%h", exp_bundle), $sformatf("%h", out));
    a_illegal: assert property (@(negedge clk)
        (out_valid && out.illegal) |-> (out.ctrl == 8'h00 && out.imm == 32'd0))
        else report_value("illegal ctrl/imm", "00/00000000",
                          $sformatf("%h/%h", out.ctrl, out.imm));
    a_x0: assert property (@(negedge clk) (out_valid && out.rd == 5'd0) |-> !out.ctrl.reg_w)
        else report_value("reg_w for x0", "0", "1");
    a_hold: assert property (@(negedge clk)
        hold_q |-> (out_valid == prev_valid && out == prev_out))
        else report_value("held stage", $sformatf("%b %h", prev_valid, prev_out),
                          $sformatf("%b %h", out_valid, out));
    a_flush: assert property (@(negedge clk) flush_q |-> !out_valid)
        else report_value("out_valid after flush", "0", "1");

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic drive(input logic [31:0] w, input logic v, input logic s, input logic f);
        @(negedge clk);
        instr       = w;
        instr_valid = v;
        stall       = s;
        flush       = f;
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        int n;
        // Two idle cycles let the last word reach the checks
        drive(32'd0, 1'b0, 1'b0, 1'b0);
        drive(32'd0, 1'b0, 1'b0, 1'b0);
        n = errors - test_start_errors;
        $display("%-16s %s, %0d errors", test_name, (n == 0) ? "ok" : "mismatch", n);
        tests_done++;
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        logic [12:0] row;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Garbage on the bus, nothing valid
        begin_test("reset_idle");
        for (int i = 0; i < 4; i++) begin
            drive(rand_bits(32), 1'b0, 1'b0, 1'b0);
        end
        end_test();

        begin_test("opcode_table");
        for (int k = 0; k < 11; k++) begin
            for (int i = 0; i < 32; i++) begin
                drive(rand_instr(all_ops[k]), 1'b1, 1'b0, 1'b0);
            end
        end
        end_test();

        // Slot 2 is plain I arith, slot 3 the shifts
        begin_test("imm_formats");
        for (int k = 0; k < 9; k++) begin
            for (int i = 0; i < 20; i++) begin
                w     = rand_instr(imm_ops[k]);
                w[31] = i[0];
                if (k == 2) begin
                    w[12] = 1'b0;
                end
                if (k == 3) begin
                    w[14:12] = i[1] ? 3'b101 : 3'b001;
                end
                drive(w, 1'b1, 1'b0, 1'b0);
            end
        end
        end_test();

        begin_test("illegal_and_x0");
        for (int i = 0; i < 12; i++) begin
            w = rand_bits(32);
            do begin
                r      = rand_bits(7);
                w[6:0] = r[6:0];
                row    = table_row(w[6:0]);
            end while (row[12]);
            drive(w, 1'b1, 1'b0, 1'b0);
        end
        for (int k = 0; k < 11; k++) begin
            w        = rand_instr(all_ops[k]);
            w[11:7]  = 5'd0;
            drive(w, 1'b1, 1'b0, 1'b0);
        end
        end_test();

        begin_test("stall_flush");
        drive(rand_instr(op_r), 1'b1, 1'b0, 1'b0);
        // Next word waits upstream while stalled
        w = rand_instr(op_s);
        repeat (3) drive(w, 1'b1, 1'b1, 1'b0);
        drive(w, 1'b1, 1'b0, 1'b0);
        drive(rand_instr(op_j), 1'b1, 1'b0, 1'b1);
        drive(rand_instr(op_b), 1'b0, 1'b1, 1'b0);
        drive(rand_instr(op_b), 1'b1, 1'b0, 1'b0);
        drive(rand_instr(op_u_lui), 1'b1, 1'b1, 1'b1);
        w = rand_instr(op_i_load);
        for (int i = 0; i < 16; i++) begin
            r = rand_bits(4);
            drive(w, r[0], r[1], r[2] & r[3]);
            if (!r[1]) begin
                w = rand_instr(all_ops[i % 11]);
            end
        end
        end_test();

        $display("tests %0d, errors %0d, cycles %0d", tests_done, errors, cycles);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
imm_gen.sv
ctrl_decoder.sv
decode_reg.sv
fetch_decode.sv
tb_fetch_decode.sv

// File: Makefile
# Verilator build and run for the decode stage

VERILATOR ?= verilator
TOP       ?= tb_fetch_decode
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= Simulation passed

SRCS := $(wildcard *.sv *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check for the pass line"
	@echo "  clean  remove the build directory"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
